/* design/alut_pkg.sv */
// shared definitions for the address lookup table
// widths, table depth, entry and request/response structs
// mac hash used to pick a table slot

package alut_pkg;

   // ------------------------------------------------------------------
   // widths and depth
   // ------------------------------------------------------------------
   localparam int MAC_W   = 48;
   localparam int PORT_W  = 2;            // four switch ports
   localparam int HASH_W  = 8;
   localparam int STAMP_W = 32;           // time in clock cycles
   localparam int COUNT_W = 16;
   localparam int ENTRY_W = 1 + PORT_W + MAC_W + STAMP_W;   // 83 bits
   localparam int DEPTH   = 1 << HASH_W;                     // 256 entries

   typedef logic [MAC_W-1:0]   mac_t;
   typedef logic [PORT_W-1:0]  port_t;
   typedef logic [HASH_W-1:0]  hash_t;
   typedef logic [STAMP_W-1:0] stamp_t;
   typedef logic [COUNT_W-1:0] count_t;

   // one table slot, msb first
   typedef struct packed {
      logic   valid;
      port_t  port;
      mac_t   mac;
      stamp_t stamp;                      // time of last learn
   } alut_entry_t;

   typedef struct packed {
      mac_t  src_mac;                     // learned into its hash slot
      port_t src_port;
      mac_t  dst_mac;                     // looked up
   } lookup_req_t;

   typedef struct packed {
      logic  hit;
      port_t port;                        // 0 on a miss
   } lookup_rsp_t;

   // xor of the six mac bytes
   function automatic hash_t mac_hash(input mac_t mac);
      return mac[47:40] ^ mac[39:32] ^ mac[31:24] ^ mac[23:16] ^ mac[15:8] ^ mac[7:0];
   endfunction

endpackage

/* design/alut_mem.sv */
// dual-port table storage
// add port for the address checker, age port for the age checker
// each port reads with one cycle of latency or writes in the cycle

`timescale 1ns/1ps

module alut_mem (
   input  logic                  pclk30,
   // address checker port
   input  alut_pkg::hash_t       mem_addr_add,
   input  logic                  mem_write_add,        // high = write
   input  alut_pkg::alut_entry_t mem_write_data_add,
   // age checker port
   input  alut_pkg::hash_t       mem_addr_age,
   input  logic                  mem_write_age,        // high = write
   input  alut_pkg::alut_entry_t mem_write_data_age,
   // registered read data
   output alut_pkg::alut_entry_t mem_read_data_add,
   output alut_pkg::alut_entry_t mem_read_data_age
);

   logic [alut_pkg::ENTRY_W-1:0] mem_core [alut_pkg::DEPTH];   // table array

   // ------------------------------------------------------------------
   // both ports in one process
   // ------------------------------------------------------------------
   always_ff @(posedge pclk30)
   begin
      // add port
      if (mem_write_add)
         mem_core[mem_addr_add] <= mem_write_data_add;
      else
         mem_read_data_add <= mem_core[mem_addr_add];   // old data on a collision

      // age port, same address write in same cycle is undefined
      if (mem_write_age)
         mem_core[mem_addr_age] <= mem_write_data_age;
      else
         mem_read_data_age <= mem_core[mem_addr_age];
   end

endmodule

/* design/alut_addr_checker.sv */
// address checker for the lookup table
// destination lookup and source learning, one frame per request
// fsm idle -> read_dst -> check -> done

`timescale 1ns/1ps

module alut_addr_checker (
   input  logic                  pclk30,
   input  logic                  reset,
   input  logic                  lookup_req,       // strobe
   input  alut_pkg::lookup_req_t lookup_data,
   input  alut_pkg::stamp_t      curr_time,        // from age checker
   input  alut_pkg::alut_entry_t read_data,        // add port read data
   output logic                  lookup_busy,
   output logic                  lookup_valid,     // one cycle pulse
   output alut_pkg::lookup_rsp_t lookup_rsp,
   output alut_pkg::hash_t       mem_addr,
   output logic                  mem_write,
   output alut_pkg::alut_entry_t mem_write_data
);

   typedef enum logic [1:0] {
      idle,
      read_dst,                                    // dst slot read issued
      check,                                       // compare and learn write
      done                                         // result out
   } state_t;

   state_t                state;
   state_t                state_nxt;
   alut_pkg::lookup_req_t req_q;                   // captured request
   alut_pkg::hash_t       src_hash;
   alut_pkg::hash_t       dst_hash;
   logic                  accept;
   logic                  dst_hit;

   // ------------------------------------------------------------------
   // request capture and hashing
   // ------------------------------------------------------------------
   assign accept = lookup_req && !lookup_busy;     // ignored while busy

   always_ff @(posedge pclk30)
   begin
      if (accept)
         req_q <= lookup_data;
   end

   assign src_hash = alut_pkg::mac_hash(req_q.src_mac);
   assign dst_hash = alut_pkg::mac_hash(req_q.dst_mac);

   // ------------------------------------------------------------------
   // fsm
   // ------------------------------------------------------------------
   always_comb
   begin
      state_nxt = state;
      case (state)
         idle:     if (accept) state_nxt = read_dst;
         read_dst: state_nxt = check;
         check:    state_nxt = done;
         done:
         begin
            // busy already low here, back to back request allowed
            if (accept)
               state_nxt = read_dst;
            else
               state_nxt = idle;
         end
         default:  state_nxt = idle;
      endcase
   end

   always_ff @(posedge pclk30)
   begin
      if (reset)
         state <= idle;
      else
         state <= state_nxt;
   end

   assign lookup_busy  = (state == read_dst) || (state == check);
   assign lookup_valid = (state == done);

   // ------------------------------------------------------------------
   // compare, dst entry arrives in check
   // ------------------------------------------------------------------
   assign dst_hit = read_data.valid && (read_data.mac == req_q.dst_mac);

   always_ff @(posedge pclk30)
   begin
      if (state == check)
      begin
         lookup_rsp.hit  <= dst_hit;
         lookup_rsp.port <= dst_hit ? read_data.port : '0;   // port 0 on a miss
      end
   end

   // ------------------------------------------------------------------
   // memory port
   // ------------------------------------------------------------------
   // read dst in read_dst, write src in check, so no self hit
   assign mem_addr  = (state == check) ? src_hash : dst_hash;
   assign mem_write = (state == check);

   always_comb
   begin
      mem_write_data.valid = 1'b1;
      mem_write_data.port  = req_q.src_port;
      mem_write_data.mac   = req_q.src_mac;
      mem_write_data.stamp = curr_time;            // learn time
   end

endmodule

/* design/alut_age_checker.sv */
// age checker for the lookup table
// free-running time base and continuous table sweep
// stale entries lose their valid bit and are counted

`timescale 1ns/1ps

module alut_age_checker (
   input  logic                  pclk30,
   input  logic                  reset,
   input  logic                  age_enable,       // level, sweep runs while high
   input  alut_pkg::stamp_t      age_limit,
   input  logic                  lookup_busy,      // from address checker
   input  alut_pkg::alut_entry_t read_data,        // age port read data
   output alut_pkg::stamp_t      curr_time,
   output alut_pkg::hash_t       mem_addr,
   output logic                  mem_write,
   output alut_pkg::alut_entry_t mem_write_data,
   output alut_pkg::count_t      aged_count,       // saturating
   output logic                  sweep_done        // one cycle pulse
);

   typedef enum logic [1:0] {
      read,                                        // issue read of sweep_idx
      compare,                                     // entry back, apply age rule
      invalidate,                                  // write back with valid low
      hold                                         // wait out a lookup
   } state_t;

   state_t           state;
   alut_pkg::hash_t  sweep_idx;
   alut_pkg::stamp_t entry_age;
   logic             busy_q;
   logic             write_blocked;
   logic             keep;
   logic             last_idx;

   // ------------------------------------------------------------------
   // time base
   // ------------------------------------------------------------------
   always_ff @(posedge pclk30)
   begin
      if (reset)
         curr_time <= '0;
      else
         curr_time <= curr_time + 1'b1;            // wraps at 2^32
   end

   // ------------------------------------------------------------------
   // age rule
   // ------------------------------------------------------------------
   assign entry_age = curr_time - read_data.stamp;   // modulo 2^32
   // x valid makes keep x, which falls into the stale branch
   assign keep      = !read_data.valid || (entry_age <= age_limit);
   assign last_idx  = (sweep_idx == alut_pkg::hash_t'(alut_pkg::DEPTH - 1));

   // busy_q covers the learn write one cycle before busy falls
   assign write_blocked = lookup_busy || busy_q;

   // ------------------------------------------------------------------
   // sweep fsm
   // ------------------------------------------------------------------
   always_ff @(posedge pclk30)
   begin
      if (reset)
      begin
         state      <= read;
         sweep_idx  <= '0;
         aged_count <= '0;
         sweep_done <= 1'b0;
         busy_q     <= 1'b0;
      end
      else
      begin
         busy_q     <= lookup_busy;
         sweep_done <= 1'b0;                       // default low
         case (state)
            read:
               if (age_enable) state <= compare;   // rests here when disabled
            compare:
            begin
               if (keep)
               begin
                  sweep_idx  <= sweep_idx + 1'b1;
                  sweep_done <= last_idx;
                  state      <= read;
               end
               else if (write_blocked)
                  state <= hold;                   // entry may change, re-read
               else
                  state <= invalidate;
            end
            invalidate:
            begin
               if (aged_count != '1)
                  aged_count <= aged_count + 1'b1;
               sweep_idx  <= sweep_idx + 1'b1;
               sweep_done <= last_idx;
               state      <= read;
            end
            hold:
               if (!write_blocked) state <= read;
            default:
               state <= read;
         endcase
      end
   end

   // ------------------------------------------------------------------
   // memory port
   // ------------------------------------------------------------------
   assign mem_addr  = sweep_idx;
   assign mem_write = (state == invalidate);

   always_comb
   begin
      mem_write_data       = read_data;            // reread in compare, still current
      mem_write_data.valid = 1'b0;
   end

endmodule

/* design/alut_top.sv */
// top level of the address lookup table
// address checker and age checker sharing the dual-port table

`timescale 1ns/1ps

module alut_top (
   input  logic                  pclk30,
   input  logic                  reset,
   input  logic                  lookup_req,
   input  alut_pkg::lookup_req_t lookup_data,
   input  logic                  age_enable,
   input  alut_pkg::stamp_t      age_limit,
   output logic                  lookup_busy,
   output logic                  lookup_valid,
   output alut_pkg::lookup_rsp_t lookup_rsp,
   output alut_pkg::count_t      aged_count,
   output logic                  sweep_done
);

   alut_pkg::stamp_t      curr_time;               // age -> addr checker

   // add port
   alut_pkg::hash_t       addr_add;
   logic                  write_add;
   alut_pkg::alut_entry_t write_data_add;
   alut_pkg::alut_entry_t read_data_add;

   // age port
   alut_pkg::hash_t       addr_age;
   logic                  write_age;
   alut_pkg::alut_entry_t write_data_age;
   alut_pkg::alut_entry_t read_data_age;

   alut_addr_checker addr_checker_i (
      .pclk30         (pclk30),
      .reset          (reset),
      .lookup_req     (lookup_req),
      .lookup_data    (lookup_data),
      .curr_time      (curr_time),
      .read_data      (read_data_add),
      .lookup_busy    (lookup_busy),
      .lookup_valid   (lookup_valid),
      .lookup_rsp     (lookup_rsp),
      .mem_addr       (addr_add),
      .mem_write      (write_add),
      .mem_write_data (write_data_add)
   );

   alut_age_checker age_checker_i (
      .pclk30         (pclk30),
      .reset          (reset),
      .age_enable     (age_enable),
      .age_limit      (age_limit),
      .lookup_busy    (lookup_busy),
      .read_data      (read_data_age),
      .curr_time      (curr_time),
      .mem_addr       (addr_age),
      .mem_write      (write_age),
      .mem_write_data (write_data_age),
      .aged_count     (aged_count),
      .sweep_done     (sweep_done)
   );

   alut_mem mem_i (
      .pclk30             (pclk30),
      .mem_addr_add       (addr_add),
      .mem_write_add      (write_add),
      .mem_write_data_add (write_data_add),
      .mem_addr_age       (addr_age),
      .mem_write_age      (write_age),
      .mem_write_data_age (write_data_age),
      .mem_read_data_add  (read_data_add),
      .mem_read_data_age  (read_data_age)
   );

endmodule

/* dv/alut_clk_gen.sv */
// clock and reset generator for the testbench
// 40 ns clock, reset high for 8 cycles, restartable

`timescale 1ns/1ps

module alut_clk_gen (
   input  logic reset_req,                   // rising edge starts another reset pulse
   output logic pclk30,
   output logic reset
);

   localparam int HALF_PERIOD  = 20;         // ns
   localparam int RESET_CYCLES = 8;

   initial
   begin
      pclk30 = 1'b0;
      forever #(HALF_PERIOD) pclk30 = ~pclk30;
   end

   // reset moves on the falling edge like the other inputs
   initial
   begin
      reset = 1'b1;
      forever
      begin
         repeat (RESET_CYCLES) @(negedge pclk30);
         reset = 1'b0;
         @(posedge reset_req);
         @(negedge pclk30);
         reset = 1'b1;
      end
   end

endmodule

/* dv/alut_checker.sv */
// result monitor for the lookup table
// follows accepted requests through the 3 cycle lookup
// compares busy, valid, lookup results and aged count

`timescale 1ns/1ps

module alut_checker (
   input  logic                  pclk30,
   input  logic                  reset,
   input  logic                  lookup_req,
   input  logic                  lookup_busy,
   input  logic                  lookup_valid,
   input  alut_pkg::lookup_rsp_t lookup_rsp,
   input  alut_pkg::count_t      aged_count,
   input  logic                  exp_hit,          // taken on accept
   input  alut_pkg::port_t       exp_port,
   input  logic                  aged_check,       // strobe
   input  alut_pkg::count_t      exp_aged,
   output int                    value_errors,
   output int                    timing_errors,
   output int                    rsp_count         // lookup_valid pulses seen
);

   typedef struct packed {
      logic            pending;
      logic            hit;
      alut_pkg::port_t port;
   } slot_t;

   slot_t stage [3];                               // stage 0 = cycle after accept

   initial
   begin
      value_errors  = 0;
      timing_errors = 0;
      rsp_count     = 0;
   end

   // ------------------------------------------------------------------
   // sampled on the rising edge, inputs settle on the falling edge
   // ------------------------------------------------------------------
   always @(posedge pclk30)
   begin : compare
      logic accept;
      logic busy_exp;
      accept   = lookup_req && !lookup_busy;
      busy_exp = stage[0].pending || stage[1].pending;   // cycles 1 and 2
      if (reset)
      begin
         for (int s = 0; s < 3; s++)
            stage[s] = '0;
      end
      else
      begin
         if (lookup_busy !== busy_exp)
         begin
            timing_errors++;
            $display("ERROR lookup_busy: expected %h, got %h", busy_exp, lookup_busy);
         end
         if (lookup_valid !== stage[2].pending)    // exactly cycle 3
         begin
            timing_errors++;
            $display("ERROR lookup_valid: expected %h, got %h", stage[2].pending, lookup_valid);
         end
         if (lookup_valid === 1'b1)
         begin
            rsp_count++;
            if (stage[2].pending && lookup_rsp.hit !== stage[2].hit)
            begin
               value_errors++;
               $display("ERROR lookup_rsp.hit: expected %h, got %h", stage[2].hit, lookup_rsp.hit);
            end
            if (stage[2].pending && lookup_rsp.port !== stage[2].port)
            begin
               value_errors++;
               $display("ERROR lookup_rsp.port: expected %h, got %h",
                        stage[2].port, lookup_rsp.port);
            end
         end
         if (aged_check && aged_count !== exp_aged)
         begin
            value_errors++;
            $display("ERROR aged_count: expected %h, got %h", exp_aged, aged_count);
         end
         stage[2] = stage[1];
         stage[1] = stage[0];
         stage[0] = '{pending: accept, hit: exp_hit, port: exp_port};
      end
   end

endmodule

/* dv/alut_props.sv */
// concurrent assertions on the lookup table outputs
// bound into alut_top

`timescale 1ns/1ps

module alut_props (
   input logic             pclk30,
   input logic             reset,
   input logic             lookup_busy,
   input logic             lookup_valid,
   input logic             sweep_done,
   input alut_pkg::count_t aged_count
);

   // result pulse lasts one cycle
   a_valid_single: assert property (@(posedge pclk30) disable iff (reset)
      lookup_valid |=> !lookup_valid)
      else $error("lookup_valid high in two consecutive cycles");

   a_valid_after_busy: assert property (@(posedge pclk30) disable iff (reset)
      lookup_valid |-> $past(lookup_busy))
      else $error("lookup_valid without lookup_busy in the cycle before");

   // quiet outputs once reset has been seen
   a_reset_quiet: assert property (@(posedge pclk30)
      reset && $past(reset) |-> !sweep_done && !lookup_valid)
      else $error("sweep_done or lookup_valid high during reset");

   a_count_up: assert property (@(posedge pclk30) disable iff (reset)
      !$past(reset) |-> aged_count >= $past(aged_count))
      else $error("aged_count decreased");

endmodule

bind alut_top alut_props props_i (
   .pclk30       (pclk30),
   .reset        (reset),
   .lookup_busy  (lookup_busy),
   .lookup_valid (lookup_valid),
   .sweep_done   (sweep_done),
   .aged_count   (aged_count)
);

/* dv/alut_tb.sv */
// testbench top for the address lookup table
// stimulus table with expected results, clear and aging phases
// watchdog and closing error summary

`timescale 1ns/1ps

module alut_tb;

   localparam int NUM_ROWS        = 13;
   localparam int AGE_AT          = 9;            // aging phase runs before this row
   localparam int NUM_LEARNED     = 4;            // slots 13, 20, 31, 46
   localparam int SWEEP_CYCLES    = 768;          // 256 entries, 3 cycles worst case
   localparam int RSP_TIMEOUT     = 16;
   localparam int WATCHDOG_CYCLES = NUM_ROWS * 8 + 3 * SWEEP_CYCLES + 200;

   // hash is the xor of the six bytes
   localparam alut_pkg::mac_t MAC_A = 48'h02_00_00_00_00_11;   // hash 13
   localparam alut_pkg::mac_t MAC_B = 48'h02_00_00_00_01_10;   // hash 13 too, replaces a
   localparam alut_pkg::mac_t MAC_C = 48'h02_00_00_00_00_22;   // hash 20
   localparam alut_pkg::mac_t MAC_D = 48'h02_00_00_00_00_33;   // hash 31
   localparam alut_pkg::mac_t MAC_E = 48'h02_00_00_00_00_44;   // hash 46
   localparam alut_pkg::mac_t MAC_F = 48'h0a_00_00_00_00_55;   // hash 5f

   typedef struct packed {
      alut_pkg::mac_t  src_mac;
      alut_pkg::port_t src_port;
      alut_pkg::mac_t  dst_mac;
      logic            exp_hit;
      alut_pkg::port_t exp_port;
      logic [1:0]      hold;                      // cycles lookup_req stays high
   } row_t;

   logic                  pclk30;
   logic                  reset;
   logic                  reset_req;
   logic                  lookup_req;
   alut_pkg::lookup_req_t lookup_data;
   logic                  age_enable;
   alut_pkg::stamp_t      age_limit;
   logic                  lookup_busy;
   logic                  lookup_valid;
   alut_pkg::lookup_rsp_t lookup_rsp;
   alut_pkg::count_t      aged_count;
   logic                  sweep_done;
   logic                  exp_hit;
   alut_pkg::port_t       exp_port;
   logic                  aged_check;
   alut_pkg::count_t      exp_aged;
   int                    value_errors;
   int                    timing_errors;
   int                    rsp_count;
   int                    other_errors = 0;       // timeouts and counts
   row_t                  rows [NUM_ROWS];

   alut_clk_gen clk_gen_i (.reset_req(reset_req), .pclk30(pclk30), .reset(reset));

   alut_top dut_i (
      .pclk30       (pclk30),
      .reset        (reset),
      .lookup_req   (lookup_req),
      .lookup_data  (lookup_data),
      .age_enable   (age_enable),
      .age_limit    (age_limit),
      .lookup_busy  (lookup_busy),
      .lookup_valid (lookup_valid),
      .lookup_rsp   (lookup_rsp),
      .aged_count   (aged_count),
      .sweep_done   (sweep_done)
   );

   alut_checker checker_i (.*);

   // ------------------------------------------------------------------
   // stimulus table: src mac, src port, dst mac, hit, port, hold
   // ------------------------------------------------------------------
   task automatic load_rows();
      rows[0]  = '{MAC_A, 2'd2, MAC_F, 1'b0, 2'd0, 2'd1};   // empty table misses
      rows[1]  = '{MAC_C, 2'd1, MAC_A, 1'b1, 2'd2, 2'd1};
      rows[2]  = '{MAC_D, 2'd3, MAC_D, 1'b0, 2'd0, 2'd1};   // self lookup, read first
      rows[3]  = '{MAC_E, 2'd0, MAC_D, 1'b1, 2'd3, 2'd1};
      rows[4]  = '{MAC_E, 2'd0, MAC_C, 1'b1, 2'd1, 2'd1};
      rows[5]  = '{MAC_B, 2'd3, MAC_A, 1'b1, 2'd2, 2'd3};   // held while busy
      rows[6]  = '{MAC_C, 2'd1, MAC_A, 1'b0, 2'd0, 2'd1};   // a replaced by b
      rows[7]  = '{MAC_C, 2'd1, MAC_B, 1'b1, 2'd3, 2'd1};
      rows[8]  = '{MAC_D, 2'd3, MAC_E, 1'b1, 2'd0, 2'd1};   // hit on port 0
      rows[9]  = '{MAC_F, 2'd1, MAC_B, 1'b0, 2'd0, 2'd1};   // all aged out
      rows[10] = '{MAC_F, 2'd1, MAC_C, 1'b0, 2'd0, 2'd1};
      rows[11] = '{MAC_F, 2'd1, MAC_D, 1'b0, 2'd0, 2'd1};
      rows[12] = '{MAC_F, 2'd1, MAC_E, 1'b0, 2'd0, 2'd1};
   endtask

   task automatic apply_row(input int idx);
      int wait_cycles;
      wait_cycles          = 0;
      lookup_data.src_mac  = rows[idx].src_mac;
      lookup_data.src_port = rows[idx].src_port;
      lookup_data.dst_mac  = rows[idx].dst_mac;
      exp_hit              = rows[idx].exp_hit;
      exp_port             = rows[idx].exp_port;
      lookup_req           = 1'b1;
      repeat (rows[idx].hold) @(negedge pclk30);
      lookup_req = 1'b0;
      while (!lookup_valid && wait_cycles < RSP_TIMEOUT)
      begin
         @(negedge pclk30);
         wait_cycles++;
      end
      if (!lookup_valid)
      begin
         other_errors++;
         $display("row %0d got no lookup_valid within %0d cycles", idx, RSP_TIMEOUT);
      end
   endtask

   task automatic wait_sweep_done();
      int n;
      n = 0;
      do
      begin
         @(negedge pclk30);
         n++;
      end while (!sweep_done && n < SWEEP_CYCLES + 16);
      if (!sweep_done)
      begin
         other_errors++;
         $display("sweep_done did not arrive within %0d cycles", SWEEP_CYCLES + 16);
      end
   endtask

   task automatic check_aged(input alut_pkg::count_t expected);
      exp_aged   = expected;
      aged_check = 1'b1;
      @(negedge pclk30);
      aged_check = 1'b0;
   endtask

   // second reset clears counters and time, table contents stay
   task automatic restart_reset();
      reset_req = 1'b1;
      @(posedge reset);
      reset_req = 1'b0;
      @(negedge reset);
   endtask

   task automatic run_aging();
      age_limit  = 32'd10;
      age_enable = 1'b1;
      wait_sweep_done();                           // first may start mid table
      wait_sweep_done();
      age_enable = 1'b0;
      check_aged(alut_pkg::count_t'(NUM_LEARNED));
   endtask

   // ------------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------------
   initial
   begin : main
      reset_req   = 1'b0;
      lookup_req  = 1'b0;
      lookup_data = '0;
      age_enable  = 1'b0;
      age_limit   = '0;
      exp_hit     = 1'b0;
      exp_port    = '0;
      aged_check  = 1'b0;
      exp_aged    = '0;
      load_rows();
      @(negedge reset);
      // limit 0, clears every valid or unknown entry
      age_enable = 1'b1;
      wait_sweep_done();
      age_enable = 1'b0;
      restart_reset();
      for (int i = 0; i < NUM_ROWS; i++)
      begin
         if (i == AGE_AT)
            run_aging();
         apply_row(i);
      end
      repeat (4) @(negedge pclk30);
      if (rsp_count != NUM_ROWS)
      begin
         other_errors++;
         $display("saw %0d lookup results, expected %0d", rsp_count, NUM_ROWS);
      end
      $display("errors: %0d value, %0d timing, %0d other",
               value_errors, timing_errors, other_errors);
      if (value_errors + timing_errors + other_errors == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

   initial
   begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge pclk30);
      $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
      $display("Simulation FAILED");
      $finish;
   end

endmodule

/* alut_top.f */
design/alut_pkg.sv
design/alut_mem.sv
design/alut_addr_checker.sv
design/alut_age_checker.sv
design/alut_top.sv
dv/alut_clk_gen.sv
dv/alut_checker.sv
dv/alut_props.sv
dv/alut_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the lookup table testbench with verilator
set -eo pipefail

cd "$(dirname "$0")"

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
   --top-module alut_tb -Mdir "$OBJ" -o alut_sim \
   -f alut_top.f

"./$OBJ/alut_sim" 2>&1 | tee "$LOG"

if grep -qx "Simulation PASSED" "$LOG"; then
   echo "result: pass"
else
   echo "result: fail, see $LOG"
   exit 1
fi
